/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module core_status_tb -f vlog.f > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vcore_status_tb > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL: simulation ended without a result"; exit 1; }

/* src/core_except_fsm.sv */
`timescale 1ns/1ps

module core_except_fsm
	import core_uarch_pkg::*;
	import core_except_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     irq,
	input  logic                     fiq,
	input  logic                     exc_req,
	input  core_except_pkg::exc_kind exc_kind,
	input  logic                     exc_return,
	input  logic                     ext_write,
	input  logic                     ext_saved,
	input  word                      ext_wr,
	input  logic                     alu_en,
	input  psr_mode                  mode,
	input  psr_intmask               mask,
	input  word                      psr_rd,
	output logic                     write,
	output logic                     saved,
	output logic                     privileged,
	output word                      psr_wr,
	output logic                     update_flags,
	output logic                     busy,
	output word                      vector,
	output logic                     vector_valid
);

	typedef enum logic [2:0] {
		idle,
		enter,
		save,
		fetch_spsr,
		restore
	} fsm_state;

	fsm_state   state;
	logic       sel_valid;
	logic       ret_ok;
	psr_mode    sel_mode;
	psr_intmask sel_mask;
	word        sel_vector;
	psr_word    captured;
	psr_word    entry_word;
	psr_mode    target;
	psr_intmask set_mask;
	word        vector_q;

	// Synchronous exceptions win over fiq, and fiq wins over irq
	always_comb begin
		sel_valid = 1'b1;
		sel_mode = mode_svc;
		sel_mask = entry_mask_svc;
		sel_vector = vec_svc;
		if (exc_req && exc_kind != exc_none) begin
			case (exc_kind)
				exc_und: begin
					sel_mode = mode_und;
					sel_mask = entry_mask_und;
					sel_vector = vec_und;
				end
				exc_abt: begin
					sel_mode = mode_abt;
					sel_mask = entry_mask_abt;
					sel_vector = vec_abt;
				end
				default: ;
			endcase
		end else if (fiq && !mask.f) begin
			sel_mode = mode_fiq;
			sel_mask = entry_mask_fiq;
			sel_vector = vec_fiq;
		end else if (irq && !mask.i) begin
			sel_mode = mode_irq;
			sel_mask = entry_mask_irq;
			sel_vector = vec_irq;
		end else begin
			sel_valid = 1'b0;
		end
	end

	// Return only makes sense from a mode that owns an SPSR
	assign ret_ok = exc_return && (mode == mode_fiq || mode == mode_irq
		|| mode == mode_svc || mode == mode_abt || mode == mode_und);

	always_comb begin
		entry_word = captured;
		entry_word.aif = captured.aif | set_mask;
		entry_word.m = target;
	end

	// While idle the outside request passes, except on the cycle a request is taken
	always_comb begin
		write = ext_write;
		saved = ext_saved;
		privileged = 1'b0;
		psr_wr = ext_wr;
		update_flags = alu_en;
		case (state)
			idle: begin
				if (sel_valid || ret_ok) begin
					write = 1'b0;
					saved = 1'b0;
					update_flags = 1'b0;
				end
			end
			enter: begin
				write = 1'b1;
				saved = 1'b0;
				privileged = 1'b1;
				psr_wr = entry_word;
				update_flags = 1'b0;
			end
			save: begin
				write = 1'b1;
				saved = 1'b1;
				privileged = 1'b1;
				psr_wr = captured;
				update_flags = 1'b0;
			end
			fetch_spsr: begin
				write = 1'b0;
				saved = 1'b1;
				update_flags = 1'b0;
			end
			default: begin
				write = 1'b1;
				saved = 1'b0;
				privileged = 1'b1;
				psr_wr = captured;
				update_flags = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
		end else begin
			case (state)
				idle:
					if (sel_valid)
						state <= enter;
					else if (ret_ok)
						state <= fetch_spsr;
				enter:      state <= save;
				fetch_spsr: state <= restore;
				default:    state <= idle;
			endcase
		end
	end

	// The captured word is the old CPSR on entry and the SPSR on return
	always_ff @(posedge clk) begin
		if (state == idle && sel_valid) begin
			captured <= psr_rd;
			target <= sel_mode;
			set_mask <= sel_mask;
			vector_q <= sel_vector;
		end else if (state == fetch_spsr) begin
			captured <= psr_rd;
		end
	end

	assign busy = state != idle;
	assign vector = vector_q;
	assign vector_valid = state == save;

endmodule

/* src/core_except_pkg.sv */
package core_except_pkg;

	import core_uarch_pkg::*;

	// Synchronous exceptions raised from inside the core
	typedef enum logic [1:0] {
		exc_none,
		exc_und,
		exc_svc,
		exc_abt
	} exc_kind;

	// Offsets into the exception vector table
	localparam word vec_und = 32'h0000_0004;
	localparam word vec_svc = 32'h0000_0008;
	localparam word vec_abt = 32'h0000_0010;
	localparam word vec_irq = 32'h0000_0018;
	localparam word vec_fiq = 32'h0000_001c;

	// Mask bits that each entry sets
	// Entry ORs them into the current mask, so bits not listed here stay as they were
	localparam psr_intmask entry_mask_und = 3'b010;
	localparam psr_intmask entry_mask_svc = 3'b010;
	localparam psr_intmask entry_mask_abt = 3'b110;
	localparam psr_intmask entry_mask_irq = 3'b110;
	localparam psr_intmask entry_mask_fiq = 3'b111;

endpackage

/* src/core_flags_alu.sv */
`timescale 1ns/1ps

module core_flags_alu
	import core_uarch_pkg::*;
(
	input  core_uarch_pkg::alu_op alu_op,
	input  word                   a,
	input  word                   b,
	input  psr_flags              flags,
	output word                   result,
	output psr_flags              alu_flags,
	output logic                  v_valid
);

	logic [32:0] sum;
	logic        overflow;

	// Subtraction adds the inverted operand plus one
	// The carry out is then the ARM "no borrow" bit
	always_comb begin
		sum = 33'd0;
		overflow = 1'b0;
		v_valid = 1'b0;
		case (alu_op)
			alu_add: begin
				sum = {1'b0, a} + {1'b0, b};
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
				v_valid = 1'b1;
			end
			alu_sub: begin
				sum = {1'b0, a} + {1'b0, ~b} + 33'd1;
				overflow = (a[31] != b[31]) && (sum[31] != a[31]);
				v_valid = 1'b1;
			end
			alu_and:
				sum = {1'b0, a & b};
			default:
				sum = {1'b0, a | b};
		endcase
	end

	assign result = sum[31:0];

	// Logical operations leave carry clear and keep the previous overflow
	assign alu_flags = {result[31], result == 32'd0, sum[32], v_valid ? overflow : flags.v};

endmodule

/* src/core_psr.sv */
`timescale 1ns/1ps

module core_psr
	import core_uarch_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       write,
	input  logic       saved,
	input  logic       privileged,
	input  logic       update_flags,
	input  logic       alu_v_valid,
	input  psr_flags   alu_flags,
	input  word        psr_wr,
	output psr_flags   flags,
	output psr_intmask mask,
	output psr_mode    mode,
	output word        psr_rd
);

	logic     t;
	word      spsr [5];
	int       slot;
	psr_word  wr;
	psr_flags cpsr_flags;
	psr_flags pend_flags;
	logic     pend;

	assign wr = psr_wr;

	function automatic int spsr_slot(psr_mode m);
		case (m)
			mode_fiq: return 0;
			mode_irq: return 1;
			mode_svc: return 2;
			mode_abt: return 3;
			mode_und: return 4;
			default:  return -1;
		endcase
	endfunction

	function automatic logic mode_valid(psr_mode m);
		return spsr_slot(m) >= 0 || m == mode_usr || m == mode_sys;
	endfunction

	assign slot = spsr_slot(mode);

	// A flag update waits one cycle in pend_flags and then commits to the CPSR
	// A CPSR write on the commit edge wins and the pending update is lost
	assign flags = pend ? pend_flags : cpsr_flags;

	always_comb begin
		if (saved)
			psr_rd = (slot < 0) ? 32'd0 : spsr[slot];
		else
			psr_rd = {flags, 19'd0, mask, t, mode};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cpsr_flags <= 4'b0000;
			pend_flags <= 4'b0000;
			pend <= 1'b0;
			mask <= 3'b111;
			t <= 1'b0;
			mode <= mode_svc;
			for (int i = 0; i < 5; i++)
				spsr[i] <= 32'd0;
		end else begin
			pend <= update_flags;
			// V only follows the ALU when the operation defines it
			if (update_flags)
				pend_flags <= {alu_flags.n, alu_flags.z, alu_flags.c,
					alu_v_valid ? alu_flags.v : flags.v};
			if (write && saved) begin
				if (slot >= 0)
					spsr[slot] <= psr_wr;
			end else if (write) begin
				cpsr_flags <= wr.nzcv;
				if (privileged || mode != mode_usr) begin
					mask <= wr.aif;
					t <= wr.t;
					if (mode_valid(wr.m))
						mode <= wr.m;
				end
			end else if (pend) begin
				cpsr_flags <= pend_flags;
			end
		end
	end

endmodule

/* src/core_status.sv */
`timescale 1ns/1ps

module core_status
	import core_uarch_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     alu_en,
	input  core_uarch_pkg::alu_op    alu_op,
	input  word                      alu_a,
	input  word                      alu_b,
	input  logic                     psr_write,
	input  logic                     psr_saved,
	input  word                      psr_wr,
	input  logic                     irq,
	input  logic                     fiq,
	input  logic                     exc_req,
	input  core_except_pkg::exc_kind exc_kind,
	input  logic                     exc_return,
	output word                      alu_result,
	output psr_flags                 flags,
	output psr_intmask               mask,
	output psr_mode                  mode,
	output word                      psr_rd,
	output logic                     busy,
	output word                      vector,
	output logic                     vector_valid
);

	psr_flags alu_nzcv;
	logic     alu_v_valid;
	logic     update_flags;
	logic     fsm_write;
	logic     fsm_saved;
	logic     fsm_privileged;
	word      fsm_wr;

	core_flags_alu i_core_flags_alu (
		.alu_op    (alu_op),
		.a         (alu_a),
		.b         (alu_b),
		.flags     (flags),
		.result    (alu_result),
		.alu_flags (alu_nzcv),
		.v_valid   (alu_v_valid)
	);

	core_psr i_core_psr (
		.clk          (clk),
		.arst_n       (arst_n),
		.write        (fsm_write),
		.saved        (fsm_saved),
		.privileged   (fsm_privileged),
		.update_flags (update_flags),
		.alu_v_valid  (alu_v_valid),
		.alu_flags    (alu_nzcv),
		.psr_wr       (fsm_wr),
		.flags        (flags),
		.mask         (mask),
		.mode         (mode),
		.psr_rd       (psr_rd)
	);

	core_except_fsm i_core_except_fsm (
		.clk          (clk),
		.arst_n       (arst_n),
		.irq          (irq),
		.fiq          (fiq),
		.exc_req      (exc_req),
		.exc_kind     (exc_kind),
		.exc_return   (exc_return),
		.ext_write    (psr_write),
		.ext_saved    (psr_saved),
		.ext_wr       (psr_wr),
		.alu_en       (alu_en),
		.mode         (mode),
		.mask         (mask),
		.psr_rd       (psr_rd),
		.write        (fsm_write),
		.saved        (fsm_saved),
		.privileged   (fsm_privileged),
		.psr_wr       (fsm_wr),
		.update_flags (update_flags),
		.busy         (busy),
		.vector       (vector),
		.vector_valid (vector_valid)
	);

endmodule

/* src/core_uarch_pkg.sv */
package core_uarch_pkg;

	typedef logic [31:0] word;

	// Condition flags in the order they sit in the status word
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		logic a;
		logic i;
		logic f;
	} psr_intmask;

	typedef logic [4:0] psr_mode;

	// Status word as MRS and MSR see it
	// Reserved bits always read as zero
	typedef struct packed {
		psr_flags    nzcv;
		logic [18:0] reserved;
		psr_intmask  aif;
		logic        t;
		psr_mode     m;
	} psr_word;

	localparam psr_mode mode_usr = 5'b10000;
	localparam psr_mode mode_fiq = 5'b10001;
	localparam psr_mode mode_irq = 5'b10010;
	localparam psr_mode mode_svc = 5'b10011;
	localparam psr_mode mode_abt = 5'b10111;
	localparam psr_mode mode_und = 5'b11011;
	localparam psr_mode mode_sys = 5'b11111;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_orr
	} alu_op;

endpackage

/* test/core_status_tb.sv */
`timescale 1ns/1ps

module core_status_tb
	import core_uarch_pkg::*;
	import core_except_pkg::*;
;

	logic       clk;
	logic       arst_n;
	logic       alu_en;
	alu_op      op_sel;
	word        alu_a;
	word        alu_b;
	logic       psr_write;
	logic       psr_saved;
	word        psr_wr;
	logic       irq;
	logic       fiq;
	logic       exc_req;
	exc_kind    kind_sel;
	logic       exc_return;
	word        alu_result;
	psr_flags   flags;
	psr_intmask mask;
	psr_mode    mode;
	word        psr_rd;
	logic       busy;
	word        vector;
	logic       vector_valid;

	// Reference model of the architectural status state
	psr_flags   exp_flags;
	psr_intmask exp_mask;
	logic       exp_t;
	psr_mode    exp_mode;
	word        exp_spsr [5];
	word        rng;
	word        usr_word;

	core_status i_core_status (
		.clk          (clk),
		.arst_n       (arst_n),
		.alu_en       (alu_en),
		.alu_op       (op_sel),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.psr_write    (psr_write),
		.psr_saved    (psr_saved),
		.psr_wr       (psr_wr),
		.irq          (irq),
		.fiq          (fiq),
		.exc_req      (exc_req),
		.exc_kind     (kind_sel),
		.exc_return   (exc_return),
		.alu_result   (alu_result),
		.flags        (flags),
		.mask         (mask),
		.mode         (mode),
		.psr_rd       (psr_rd),
		.busy         (busy),
		.vector       (vector),
		.vector_valid (vector_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word xorshift();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	task automatic report_failure(string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_val(string name, word got, word exp);
		assert (got === exp)
		else report_failure($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	function automatic int spsr_slot(psr_mode m);
		case (m)
			mode_fiq: return 0;
			mode_irq: return 1;
			mode_svc: return 2;
			mode_abt: return 3;
			mode_und: return 4;
			default:  return -1;
		endcase
	endfunction

	function automatic logic mode_is_valid(psr_mode m);
		return spsr_slot(m) >= 0 || m == mode_usr || m == mode_sys;
	endfunction

	function automatic word cpsr_word();
		return {exp_flags, 19'd0, exp_mask, exp_t, exp_mode};
	endfunction

	function automatic word expected_spsr();
		return spsr_slot(exp_mode) < 0 ? 32'd0 : exp_spsr[spsr_slot(exp_mode)];
	endfunction

	// User mode may only touch the flags unless the write is privileged
	function automatic void apply_word(word w, logic privileged);
		exp_flags = w[31:28];
		if (privileged || exp_mode != mode_usr) begin
			exp_mask = w[8:6];
			exp_t = w[5];
			if (mode_is_valid(w[4:0]))
				exp_mode = w[4:0];
		end
	endfunction

	function automatic word model_result(alu_op op, word a, word b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			default: return a | b;
		endcase
	endfunction

	// Overflow shows as a 64-bit signed result that no longer fits in 32 bits
	function automatic psr_flags model_flags(alu_op op, word a, word b, psr_flags old);
		word      r;
		longint   s;
		psr_flags f;
		r = model_result(op, a, b);
		f.n = r[31];
		f.z = (r == 32'd0);
		f.c = 1'b0;
		f.v = old.v;
		if (op == alu_add) begin
			s = longint'($signed(a)) + longint'($signed(b));
			f.c = (a + b) < a;
			f.v = s != longint'($signed(r));
		end else if (op == alu_sub) begin
			s = longint'($signed(a)) - longint'($signed(b));
			f.c = a >= b;
			f.v = s != longint'($signed(r));
		end
		return f;
	endfunction

	task automatic check_state();
		check_val("flags", {28'd0, flags}, {28'd0, exp_flags});
		check_val("mask", {29'd0, mask}, {29'd0, exp_mask});
		check_val("mode", {27'd0, mode}, {27'd0, exp_mode});
		check_val("busy", {31'd0, busy}, 32'd0);
		check_val("vector_valid", {31'd0, vector_valid}, 32'd0);
		check_val("psr_rd", psr_rd, cpsr_word());
	endtask

	task automatic alu_strobe(alu_op op, word a, word b);
		word      exp_res;
		psr_flags exp_f;
		exp_res = model_result(op, a, b);
		exp_f = model_flags(op, a, b, exp_flags);
		@(posedge clk);
		alu_en <= 1'b1;
		op_sel <= op;
		alu_a <= a;
		alu_b <= b;
		@(negedge clk);
		check_val("alu_result", alu_result, exp_res);
		@(posedge clk);
		alu_en <= 1'b0;
		exp_flags = exp_f;
		@(negedge clk);
		check_state();
	endtask

	task automatic psr_store(word w, logic to_spsr);
		@(posedge clk);
		psr_write <= 1'b1;
		psr_saved <= to_spsr;
		psr_wr <= w;
		@(posedge clk);
		psr_write <= 1'b0;
		psr_saved <= 1'b0;
		if (!to_spsr)
			apply_word(w, 1'b0);
		else if (spsr_slot(exp_mode) >= 0)
			exp_spsr[spsr_slot(exp_mode)] = w;
		@(negedge clk);
		check_state();
	endtask

	task automatic read_spsr(word exp);
		@(posedge clk);
		psr_saved <= 1'b1;
		@(negedge clk);
		check_val("psr_rd (saved)", psr_rd, exp);
		@(posedge clk);
		psr_saved <= 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (busy) begin
			if (cycles == 10)
				report_failure("Timed out waiting for busy to fall");
			cycles++;
			@(negedge clk);
		end
	endtask

	// With noise set, a CPSR write and an ALU strobe are driven while busy
	task automatic take_exception(logic req, exc_kind kind, logic irq_lvl, logic fiq_lvl,
			psr_mode target, psr_intmask set_bits, word exp_vec, logic noise);
		word old_word;
		int  edges;
		old_word = cpsr_word();
		@(posedge clk);
		exc_req <= req;
		kind_sel <= kind;
		irq <= irq_lvl;
		fiq <= fiq_lvl;
		@(posedge clk);
		exc_req <= 1'b0;
		irq <= 1'b0;
		fiq <= 1'b0;
		if (noise) begin
			psr_write <= 1'b1;
			psr_wr <= 32'hf000_00d0;
			alu_en <= 1'b1;
			op_sel <= alu_sub;
			alu_a <= 32'd0;
			alu_b <= 32'd1;
		end
		edges = 1;
		@(negedge clk);
		check_val("busy", {31'd0, busy}, 32'd1);
		while (!vector_valid) begin
			if (edges >= 8)
				report_failure("Timed out waiting for vector_valid after an exception request");
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		check_val("vector_valid latency", edges, 32'd2);
		check_val("vector", vector, exp_vec);
		exp_spsr[spsr_slot(target)] = old_word;
		exp_mode = target;
		exp_mask = exp_mask | set_bits;
		@(posedge clk);
		psr_write <= 1'b0;
		alu_en <= 1'b0;
		wait_idle();
		check_state();
		read_spsr(old_word);
	endtask

	task automatic return_from_exception();
		word restored;
		restored = expected_spsr();
		@(posedge clk);
		exc_return <= 1'b1;
		@(posedge clk);
		exc_return <= 1'b0;
		@(negedge clk);
		check_val("busy", {31'd0, busy}, 32'd1);
		wait_idle();
		apply_word(restored, 1'b1);
		check_state();
	endtask

	initial begin
		int gap;
		arst_n <= 1'b0;
		alu_en <= 1'b0;
		op_sel <= alu_add;
		alu_a <= 32'd0;
		alu_b <= 32'd0;
		psr_write <= 1'b0;
		psr_saved <= 1'b0;
		psr_wr <= 32'd0;
		irq <= 1'b0;
		fiq <= 1'b0;
		exc_req <= 1'b0;
		kind_sel <= exc_none;
		exc_return <= 1'b0;
		rng = 32'h536b;
		exp_flags = 4'b0000;
		exp_mask = 3'b111;
		exp_t = 1'b0;
		exp_mode = mode_svc;
		for (int i = 0; i < 5; i++)
			exp_spsr[i] = 32'd0;

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_state();
		read_spsr(32'd0);

		// Random ALU traffic, with an equal operand now and then to reach Z
		for (int n = 0; n < 200; n++) begin
			word r;
			word a;
			r = xorshift();
			a = xorshift();
			alu_strobe(alu_op'(r[1:0]), a, r[4:2] == 3'd0 ? a : xorshift());
			gap = int'(r[9:8] % 2'd3);
			repeat (gap) @(posedge clk);
		end

		// Invalid mode field and junk in the reserved bits
		psr_store({4'b0110, 19'h5a5a5, 3'b111, 1'b0, 5'b00101}, 1'b0);
		psr_store(32'h9000_0150, 1'b1);
		read_spsr(expected_spsr());

		// Both interrupts masked
		@(posedge clk);
		irq <= 1'b1;
		fiq <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_val("busy", {31'd0, busy}, 32'd0);
		end
		@(posedge clk);
		irq <= 1'b0;
		fiq <= 1'b0;
		@(negedge clk);
		check_state();

		psr_store(32'h2000_0013, 1'b0);
		take_exception(1'b0, exc_none, 1'b1, 1'b1, mode_fiq, 3'b111, 32'h1c, 1'b0);
		return_from_exception();
		take_exception(1'b1, exc_und, 1'b1, 1'b1, mode_und, 3'b010, 32'h04, 1'b0);
		return_from_exception();
		take_exception(1'b1, exc_abt, 1'b0, 1'b0, mode_abt, 3'b110, 32'h10, 1'b0);
		return_from_exception();
		take_exception(1'b0, exc_none, 1'b1, 1'b0, mode_irq, 3'b110, 32'h18, 1'b0);
		return_from_exception();

		// User mode keeps everything but the flags and has no SPSR
		psr_store(32'h4000_0010, 1'b0);
		psr_store(32'hb000_01d3, 1'b0);
		read_spsr(32'd0);
		psr_store(32'h7000_0013, 1'b1);
		read_spsr(32'd0);

		usr_word = cpsr_word();
		take_exception(1'b1, exc_svc, 1'b0, 1'b0, mode_svc, 3'b010, 32'h08, 1'b1);
		return_from_exception();
		check_val("psr_rd after return", psr_rd, usr_word);

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* vlog.f */
src/core_uarch_pkg.sv
src/core_except_pkg.sv
src/core_flags_alu.sv
src/core_psr.sv
src/core_except_fsm.sv
src/core_status.sv
test/core_status_tb.sv
